/* Makefile */
SRCS := $(shell cat filelist.f)
SIM := obj_dir/Vtb_decode_unit

all: run

$(SIM): $(SRCS) filelist.f
	verilator --binary --assert -j 0 --top-module tb_decode_unit -Mdir obj_dir -f filelist.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "STATUS: PASS" sim.log
	@! grep -q "STATUS: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* bench/tb_decode_unit.sv */
`timescale 1ns/1ps

module tb_decode_unit;

    localparam int                QUEUE_DEPTH = 4;
    localparam decode_pkg::word_t RESET_PC = 32'h0000_0200;
    localparam decode_pkg::word_t JUMP_TARGET = 32'h0000_1000;
    // 40 alu, 8 load-use, 16 jumps, 3 exceptions, 4 redirect, 24 back-pressure
    localparam int PLANNED_WORDS = 40 + 8 + 16 + 3 + 4 + 24;
    localparam int CYCLE_LIMIT = 20 * PLANNED_WORDS + 200;

    typedef struct packed {
        decode_pkg::word_t pc;
        decode_pkg::word_t instr;
        decode_pkg::word_t imm;
        logic [4:0]        waddr;
        logic [4:0]        raddr1;
        logic [4:0]        raddr2;
        logic [3:0]        alu;
        logic [3:0]        hints;     // push, pop, uncond, rest
        logic [11:0]       ctrl;      // wren, rden1, rden2, then lui to ebreak
        logic              valid;
        logic              exception;
        logic [3:0]        cause;
        logic [1:0]        stalls;    // bubbles expected just before this packet
    } expect_t;

    logic                       clock;
    logic                       reset;
    logic                       imem_valid;
    decode_pkg::word_t          imem_instr;
    decode_pkg::redirect_t      redirect;
    logic                       imem_ready;
    decode_pkg::decode_packet_t q;

    expect_t           ref_q[$];
    decode_pkg::word_t exp_pc;
    logic [15:0]       lfsr;
    string             test_name;
    int                errors;
    int                checks;
    int                cycles;
    int                stall_seen;

    decode_unit_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .RESET_PC(RESET_PC)) DUT (
        .clock      (clock),
        .reset      (reset),
        .imem_valid (imem_valid),
        .imem_instr (imem_instr),
        .redirect   (redirect),
        .imem_ready (imem_ready),
        .q          (q)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // galois lfsr, one step per returned bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [3:0] alu_for(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
            3'd1: return decode_pkg::alu_sll;
            3'd2: return decode_pkg::alu_slt;
            3'd3: return decode_pkg::alu_sltu;
            3'd4: return decode_pkg::alu_xor;
            3'd5: return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
            3'd6: return decode_pkg::alu_or;
            default: return decode_pkg::alu_and;
        endcase
    endfunction

    function automatic expect_t base_entry(input decode_pkg::word_t w);
        expect_t e;
        e = '0;
        e.instr = w;
        e.waddr = w[11:7];
        e.raddr1 = w[19:15];
        e.raddr2 = w[24:20];
        e.alu = decode_pkg::alu_add;
        e.valid = 1'b1;
        return e;
    endfunction

    function automatic expect_t rtype(input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [2:0] f3,
                                      input logic alt);
        expect_t e;
        e = base_entry({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011});
        e.alu = alu_for(f3, alt);
        e.ctrl = 12'b1110_0000_0000;
        return e;
    endfunction

    function automatic expect_t itype(input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm, input logic [2:0] f3);
        expect_t e;
        e = base_entry({imm, rs1, f3, rd, 7'b0010011});
        e.imm = {{20{imm[11]}}, imm};
        e.alu = alu_for(f3, (f3 == 3'd5) && imm[10]);
        e.ctrl = 12'b1100_0000_0000;
        return e;
    endfunction

    function automatic expect_t load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        expect_t e;
        e = base_entry({imm, rs1, 3'b010, rd, 7'b0000011});
        e.imm = {{20{imm[11]}}, imm};
        e.ctrl = 12'b1100_0000_1000;
        return e;
    endfunction

    function automatic logic is_link(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    function automatic logic [4:0] pick_reg();
        case (take_bits(2))
            0: return 5'd0;
            1: return 5'd1;
            2: return 5'd5;
            default: return 5'd8 + 5'(take_bits(3));
        endcase
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        field_match: assert (exp === act) else begin
            errors++;
            $display("Fail %s %s: expected %h actual %h", test_name, name, exp, act);
        end
    endtask

    // outputs are compared at the falling edge, half a cycle after q settles
    always @(negedge clock) begin
        expect_t e;
        if (!reset && cycles > 0) begin
            check_field("reset outputs", 32'd0, 32'({imem_ready, q.valid, q.exception}));
        end
        if (reset && q.stall) begin
            stall_seen++;
        end
        if (reset && (q.valid || q.exception)) begin
            if (ref_q.size() == 0) begin
                errors++;
                $display("%s: packet with pc %h came out but none was expected",
                         test_name, q.pc);
            end else begin
                e = ref_q.pop_front();
                check_field("pc", e.pc, q.pc);
                check_field("valid", 32'(e.valid), 32'(q.valid));
                check_field("exception", 32'(e.exception), 32'(q.exception));
                check_field("stall bubbles", 32'(e.stalls), stall_seen);
                check_field("ctrl", 32'(e.ctrl), 32'({q.wren, q.rden1, q.rden2, q.lui,
                            q.auipc, q.jal, q.jalr, q.branch, q.load, q.store,
                            q.ecall, q.ebreak}));
                if (e.exception) begin
                    check_field("ecause", 32'(e.cause), 32'(q.ecause));
                    check_field("etval", e.instr, q.etval);
                end else begin
                    check_field("npc", e.pc + 32'd4, q.npc);
                    check_field("waddr", 32'(e.waddr), 32'(q.waddr));
                    check_field("raddr1", 32'(e.raddr1), 32'(q.raddr1));
                    check_field("raddr2", 32'(e.raddr2), 32'(q.raddr2));
                    check_field("imm", e.imm, q.imm);
                    check_field("alu_op", 32'(e.alu), 32'(q.alu_op));
                    check_field("hints", 32'(e.hints), 32'({q.return_push, q.return_pop,
                                q.jump_uncond, q.jump_rest}));
                end
            end
            stall_seen = 0;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d packets still expected",
                     cycles, ref_q.size());
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // offers a word until it is taken, then idles for gap cycles
    task automatic send_word(input expect_t e, input int gap);
        logic ok;
        imem_valid = 1'b1;
        imem_instr = e.instr;
        ok = 1'b0;
        while (!ok) begin
            @(negedge clock);
            ok = imem_ready;
            @(posedge clock);
            #1;
        end
        e.pc = exp_pc;
        exp_pc = exp_pc + 32'd4;
        ref_q.push_back(e);
        if (gap > 0) begin
            imem_valid = 1'b0;
            repeat (gap) @(posedge clock);
            #1;
        end
    endtask

    task automatic issue_redirect(input decode_pkg::word_t target);
        imem_valid = 1'b0;
        redirect = '{jump: 1'b1, address: target};
        @(posedge clock);
        #1;
        redirect.jump = 1'b0;
        ref_q.delete();    // words still in flight are discarded
        exp_pc = target;
    endtask

    task automatic run_load_use(input int pairs, input logic dependent);
        expect_t e;
        logic [4:0] rd;
        for (int i = 0; i < pairs; i++) begin
            rd = {1'b1, 4'(take_bits(4))};
            send_word(load_word(rd, 5'(take_bits(5)), 12'(take_bits(12))), 0);
            if (dependent) begin
                e = rtype({1'b0, 4'(take_bits(4))}, rd, 5'(take_bits(5)), 3'd0, 1'b0);
                e.stalls = 2'd1;
            end else begin
                e = rtype(rd, {1'b0, 4'(take_bits(4))}, {1'b0, 4'(take_bits(4))}, 3'd4, 1'b0);
            end
            send_word(e, 0);
        end
    endtask

    initial begin
        expect_t e;
        logic [2:0] f3;
        logic [11:0] imm12;
        logic [20:0] imm21;
        logic [4:0] rd;
        logic [4:0] rs1;
        lfsr = 16'd31;
        errors = 0;
        checks = 0;
        cycles = 0;
        stall_seen = 0;
        exp_pc = RESET_PC;
        test_name = "reset";
        reset = 1'b0;
        imem_valid = 1'b0;
        imem_instr = '0;
        redirect = '{jump: 1'b0, address: '0};
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b1;

        test_name = "order";
        for (int i = 0; i < 20; i++) begin
            f3 = 3'(take_bits(3));
            send_word(rtype(5'(take_bits(5)), 5'(take_bits(5)), 5'(take_bits(5)), f3,
                            (f3 == 3'd0 || f3 == 3'd5) ? 1'(take_bits(1)) : 1'b0),
                      take_bits(2));
        end
        for (int i = 0; i < 20; i++) begin
            f3 = 3'(take_bits(3));
            imm12 = 12'(take_bits(12));
            if (f3 == 3'd1) imm12[11:5] = 7'b0;
            if (f3 == 3'd5) imm12[11:5] = take_bits(1) ? 7'b0100000 : 7'b0;
            send_word(itype(5'(take_bits(5)), 5'(take_bits(5)), imm12, f3), take_bits(2));
        end

        test_name = "load_use";
        run_load_use(2, 1'b1);
        run_load_use(2, 1'b0);

        test_name = "hints";
        for (int i = 0; i < 16; i++) begin
            rd = pick_reg();
            if (i % 2 == 0) begin
                imm21 = {20'(take_bits(20)), 1'b0};
                e = base_entry({imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd,
                                7'b1101111});
                e.imm = {{11{imm21[20]}}, imm21};
                e.ctrl = 12'b1000_0100_0000;
                if (is_link(rd)) e.hints = 4'b1000;
                else if (rd == 5'd0) e.hints = 4'b0010;
                else e.hints = 4'b0001;
            end else begin
                rs1 = pick_reg();
                imm12 = 12'(take_bits(12));
                e = base_entry({imm12, rs1, 3'b000, rd, 7'b1100111});
                e.imm = {{20{imm12[11]}}, imm12};
                e.ctrl = 12'b1100_0010_0000;
                if (is_link(rd) && is_link(rs1)) e.hints = (rd == rs1) ? 4'b1000 : 4'b1100;
                else if (is_link(rs1)) e.hints = 4'b0100;
                else if (is_link(rd)) e.hints = 4'b1000;
                else e.hints = 4'b0001;
            end
            send_word(e, take_bits(1));
        end

        test_name = "exceptions";
        e = base_entry({30'(take_bits(30)), 2'b00});
        e.valid = 1'b0;
        e.exception = 1'b1;
        e.cause = 4'd2;
        send_word(e, 1);
        e = base_entry(32'h0000_0073);
        e.exception = 1'b1;
        e.cause = 4'd11;
        e.ctrl = 12'b0000_0000_0010;
        send_word(e, 1);
        e = base_entry(32'h0010_0073);
        e.exception = 1'b1;
        e.cause = 4'd3;
        e.ctrl = 12'b0000_0000_0001;
        send_word(e, 1);

        test_name = "redirect";
        send_word(rtype(5'd3, 5'd4, 5'd6, 3'd6, 1'b0), 0);
        send_word(rtype(5'd7, 5'd9, 5'd10, 3'd7, 1'b0), 0);
        issue_redirect(JUMP_TARGET);
        send_word(itype(5'd11, 5'd12, 12'h7f0, 3'd0), 0);
        send_word(itype(5'd13, 5'd14, 12'h801, 3'd4), 2);

        test_name = "back_pressure";
        run_load_use(12, 1'b1);
        imem_valid = 1'b0;

        while (ref_q.size() != 0) @(posedge clock);
        repeat (5) @(posedge clock);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/decode_pkg.sv
hw/fetch_stage.sv
hw/instr_queue.sv
hw/base_decoder.sv
hw/decode_stage.sv
hw/decode_unit_top.sv
bench/tb_decode_unit.sv

/* hw/base_decoder.sv */
`timescale 1ns/1ps

module base_decoder (
    input  decode_pkg::word_t        instr,
    output decode_pkg::decoder_out_t decoder_out
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    decode_pkg::word_t imm_i;
    decode_pkg::word_t imm_s;
    decode_pkg::word_t imm_b;
    decode_pkg::word_t imm_u;
    decode_pkg::word_t imm_j;

    function automatic decode_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
            3'b001: return decode_pkg::alu_sll;
            3'b010: return decode_pkg::alu_slt;
            3'b011: return decode_pkg::alu_sltu;
            3'b100: return decode_pkg::alu_xor;
            3'b101: return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
            3'b110: return decode_pkg::alu_or;
            default: return decode_pkg::alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];  // low bits 11 are part of every opcode compare
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        decoder_out = '0;
        decoder_out.alu_op = decode_pkg::alu_add;
        case (opcode)
            OPC_LUI: begin
                decoder_out = '{imm: imm_u, wren: 1'b1, lui: 1'b1, valid: 1'b1,
                                alu_op: decode_pkg::alu_add, default: '0};
            end
            OPC_AUIPC: begin
                decoder_out = '{imm: imm_u, wren: 1'b1, auipc: 1'b1, valid: 1'b1,
                                alu_op: decode_pkg::alu_add, default: '0};
            end
            OPC_JAL: begin
                decoder_out = '{imm: imm_j, wren: 1'b1, jal: 1'b1, valid: 1'b1,
                                alu_op: decode_pkg::alu_add, default: '0};
            end
            OPC_JALR: begin
                decoder_out.imm = imm_i;
                decoder_out.wren = 1'b1;
                decoder_out.rden1 = 1'b1;
                decoder_out.jalr = 1'b1;
                decoder_out.valid = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                decoder_out.imm = imm_b;
                decoder_out.rden1 = 1'b1;
                decoder_out.rden2 = 1'b1;
                decoder_out.branch = 1'b1;
                decoder_out.valid = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            OPC_LOAD: begin
                decoder_out.imm = imm_i;
                decoder_out.wren = 1'b1;
                decoder_out.rden1 = 1'b1;
                decoder_out.load = 1'b1;
                decoder_out.valid = (funct3 != 3'b011) && (funct3 < 3'b110);
            end
            OPC_STORE: begin
                decoder_out.imm = imm_s;
                decoder_out.rden1 = 1'b1;
                decoder_out.rden2 = 1'b1;
                decoder_out.store = 1'b1;
                decoder_out.valid = (funct3 <= 3'b010);
            end
            OPC_IMM: begin
                decoder_out.imm = imm_i;
                decoder_out.wren = 1'b1;
                decoder_out.rden1 = 1'b1;
                // only the shifts carry funct7, and only srai may set bit 30
                decoder_out.alu_op = alu_sel(funct3, (funct3 == 3'b101) && instr[30]);
                if (funct3 == 3'b001) begin
                    decoder_out.valid = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    decoder_out.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    decoder_out.valid = 1'b1;
                end
            end
            OPC_OP: begin
                decoder_out.wren = 1'b1;
                decoder_out.rden1 = 1'b1;
                decoder_out.rden2 = 1'b1;
                decoder_out.alu_op = alu_sel(funct3, instr[30]);
                decoder_out.valid = (funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_FENCE: decoder_out.valid = (funct3 == 3'b000);  // runs as a nop
            OPC_SYSTEM: begin
                decoder_out.ecall = (instr == 32'h0000_0073);
                decoder_out.ebreak = (instr == 32'h0010_0073);
                decoder_out.valid = decoder_out.ecall | decoder_out.ebreak;
            end
            default: decoder_out.valid = 1'b0;
        endcase
    end

endmodule

/* hw/decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] word_t;     // instr words, pc, imm and etval
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  cause_t;

    localparam cause_t except_illegal_instruction = 4'd2;
    localparam cause_t except_breakpoint = 4'd3;
    localparam cause_t except_env_call_mach = 4'd11;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_packet_t;

    typedef struct packed {
        word_t   imm;
        logic    wren;
        logic    rden1;
        logic    rden2;
        logic    lui;
        logic    auipc;
        logic    jal;
        logic    jalr;
        logic    branch;
        logic    load;
        logic    store;
        logic    ecall;
        logic    ebreak;
        logic    valid;      // known encoding
        alu_op_t alu_op;
    } decoder_out_t;

    typedef struct packed {
        logic  jump;
        word_t address;
    } redirect_t;

    typedef struct packed {
        word_t     pc;
        word_t     npc;
        word_t     imm;
        reg_addr_t waddr;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        logic      wren;
        logic      rden1;
        logic      rden2;
        logic      lui;
        logic      auipc;
        logic      jal;
        logic      jalr;
        logic      branch;
        logic      load;
        logic      store;
        logic      ecall;
        logic      ebreak;
        logic      valid;
        logic      return_push;
        logic      return_pop;
        logic      jump_uncond;
        logic      jump_rest;
        logic      exception;
        cause_t    ecause;
        word_t     etval;
        logic      stall;    // bubble from a load-use hazard
        alu_op_t   alu_op;
    } decode_packet_t;

    localparam decode_packet_t init_decode_packet = '{alu_op: alu_add, default: '0};

endpackage

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       head_valid,
    input  decode_pkg::fetch_packet_t  head_packet,
    input  decode_pkg::redirect_t      redirect,
    output logic                       pop,
    output decode_pkg::decode_packet_t q
);

    decode_pkg::decoder_out_t   dec;
    decode_pkg::decode_packet_t v;
    decode_pkg::word_t          instr;
    logic link_waddr;
    logic link_raddr1;
    logic hazard;
    logic stall;
    logic clear;

    assign instr = head_packet.instr;

    base_decoder u_base_decoder (
        .instr       (instr),
        .decoder_out (dec)
    );

    // q holds the instruction now in execute
    assign hazard = q.valid & q.load &
        ((dec.rden1 & (q.waddr == instr[19:15])) | (dec.rden2 & (q.waddr == instr[24:20])));
    assign stall = head_valid & hazard & ~redirect.jump;
    assign pop = head_valid & ~hazard & ~redirect.jump;
    assign clear = stall | redirect.jump | ~head_valid;

    assign link_waddr = (instr[11:7] == 5'd1) || (instr[11:7] == 5'd5);
    assign link_raddr1 = (instr[19:15] == 5'd1) || (instr[19:15] == 5'd5);

    always_comb begin
        v = decode_pkg::init_decode_packet;
        v.pc = head_packet.pc;
        v.npc = head_packet.pc + 32'd4;
        v.imm = dec.imm;
        v.waddr = instr[11:7];
        v.raddr1 = instr[19:15];
        v.raddr2 = instr[24:20];
        v.wren = dec.wren;
        v.rden1 = dec.rden1;
        v.rden2 = dec.rden2;
        v.lui = dec.lui;
        v.auipc = dec.auipc;
        v.jal = dec.jal;
        v.jalr = dec.jalr;
        v.branch = dec.branch;
        v.load = dec.load;
        v.store = dec.store;
        v.ecall = dec.ecall;
        v.ebreak = dec.ebreak;
        v.valid = dec.valid;
        v.alu_op = dec.alu_op;

        if (dec.jal) begin
            if (link_waddr) begin
                v.return_push = 1'b1;
            end else if (instr[11:7] == 5'd0) begin
                v.jump_uncond = 1'b1;
            end else begin
                v.jump_rest = 1'b1;
            end
        end

        if (dec.jalr) begin
            if (!link_waddr && link_raddr1) begin
                v.return_pop = 1'b1;
            end else if (link_waddr && !link_raddr1) begin
                v.return_push = 1'b1;
            end else if (link_waddr && link_raddr1) begin
                v.return_push = 1'b1;
                v.return_pop = (instr[11:7] != instr[19:15]);  // coroutine swap
            end else begin
                v.jump_rest = 1'b1;
            end
        end

        if (!dec.valid) begin
            v.exception = 1'b1;
            v.ecause = decode_pkg::except_illegal_instruction;
            v.etval = instr;
        end else if (dec.ebreak) begin
            v.exception = 1'b1;
            v.ecause = decode_pkg::except_breakpoint;
            v.etval = instr;
        end else if (dec.ecall) begin
            v.exception = 1'b1;
            v.ecause = decode_pkg::except_env_call_mach;
            v.etval = instr;
        end

        if (clear) begin
            v.wren = 1'b0;
            v.rden1 = 1'b0;
            v.rden2 = 1'b0;
            v.lui = 1'b0;
            v.auipc = 1'b0;
            v.jal = 1'b0;
            v.jalr = 1'b0;
            v.branch = 1'b0;
            v.load = 1'b0;
            v.store = 1'b0;
            v.ecall = 1'b0;
            v.ebreak = 1'b0;
            v.valid = 1'b0;
            v.return_push = 1'b0;
            v.return_pop = 1'b0;
            v.jump_uncond = 1'b0;
            v.jump_rest = 1'b0;
            v.exception = 1'b0;
        end
        v.stall = stall;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            q <= decode_pkg::init_decode_packet;
        end else begin
            q <= v;
        end
    end

    a_valid_not_stall: assert property (@(posedge clock) disable iff (!reset)
        !(q.valid && q.stall));
    a_no_pop_redirect: assert property (@(posedge clock) disable iff (!reset)
        redirect.jump |-> !pop);

endmodule

/* hw/decode_unit_top.sv */
`timescale 1ns/1ps

module decode_unit_top #(
    parameter int                QUEUE_DEPTH = 4,
    parameter decode_pkg::word_t RESET_PC = '0
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       imem_valid,
    input  decode_pkg::word_t          imem_instr,
    input  decode_pkg::redirect_t      redirect,
    output logic                       imem_ready,
    output decode_pkg::decode_packet_t q
);

    logic                      push_valid;
    logic                      push_ready;
    decode_pkg::fetch_packet_t push_packet;
    logic                      head_valid;
    decode_pkg::fetch_packet_t head_packet;
    logic                      pop;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch_stage (
        .clock       (clock),
        .reset       (reset),
        .imem_valid  (imem_valid),
        .imem_instr  (imem_instr),
        .redirect    (redirect),
        .push_ready  (push_ready),
        .imem_ready  (imem_ready),
        .push_valid  (push_valid),
        .push_packet (push_packet)
    );

    instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_instr_queue (
        .clock       (clock),
        .reset       (reset),
        .push_valid  (push_valid),
        .push_packet (push_packet),
        .pop         (pop),
        .redirect    (redirect),
        .push_ready  (push_ready),
        .head_valid  (head_valid),
        .head_packet (head_packet)
    );

    decode_stage u_decode_stage (
        .clock       (clock),
        .reset       (reset),
        .head_valid  (head_valid),
        .head_packet (head_packet),
        .redirect    (redirect),
        .pop         (pop),
        .q           (q)
    );

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
    parameter decode_pkg::word_t RESET_PC = '0
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      imem_valid,
    input  decode_pkg::word_t         imem_instr,
    input  decode_pkg::redirect_t     redirect,
    input  logic                      push_ready,
    output logic                      imem_ready,
    output logic                      push_valid,
    output decode_pkg::fetch_packet_t push_packet
);

    decode_pkg::word_t pc;      // pc of the next accepted word
    logic              started; // low for the first cycle after reset
    logic              accept;

    // output slot is free, or its packet moves into the queue this edge
    assign imem_ready = started & ~redirect.jump & (~push_valid | push_ready);
    assign accept = imem_valid & imem_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            pc <= RESET_PC;
            push_valid <= 1'b0;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (redirect.jump) begin
                pc <= redirect.address;
                push_valid <= 1'b0;   // drop whatever sits in the slot
            end else if (accept) begin
                pc <= pc + 32'd4;
                push_valid <= 1'b1;
            end else if (push_ready) begin
                push_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            push_packet <= '{pc: pc, instr: imem_instr};
        end
    end

    a_push_hold: assert property (@(posedge clock) disable iff (!reset)
        push_valid && !push_ready && !redirect.jump |=> push_valid && $stable(push_packet));

endmodule

/* hw/instr_queue.sv */
`timescale 1ns/1ps

module instr_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      push_valid,
    input  decode_pkg::fetch_packet_t push_packet,
    input  logic                      pop,
    input  decode_pkg::redirect_t     redirect,
    output logic                      push_ready,
    output logic                      head_valid,
    output decode_pkg::fetch_packet_t head_packet
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(QUEUE_DEPTH);

    decode_pkg::fetch_packet_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rptr;
    logic [PTR_W-1:0] wptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign push_ready = (count != FULL);
    assign head_valid = (count != '0);
    assign head_packet = mem[rptr];
    assign do_push = push_valid & push_ready;
    assign do_pop = pop & head_valid;

    always_ff @(posedge clock) begin
        if (!reset || redirect.jump) begin
            rptr <= '0;
            wptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= (wptr == LAST) ? '0 : wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= (rptr == LAST) ? '0 : rptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wptr] <= push_packet;
        end
    end

    a_no_pop_empty: assert property (@(posedge clock) disable iff (!reset)
        pop |-> head_valid);
    a_count_bound: assert property (@(posedge clock) disable iff (!reset)
        count <= FULL);

endmodule
